//--- test/stream_cases.txt
# W name addr data | R name addr exp_data exp_resp | S name length ready_duty
# addr and data in hex, resp 0 okay 2 slverr, length and duty (1 to 100) in decimal
W buf_w0 80 a5a50000
W buf_w1 84 0badf00d
W buf_w2 88 12345678
W buf_w3 8c deadbeef
W buf_w4 90 00000004
W buf_w5 94 5a5a5a5a
W buf_w6 98 cafef00d
W buf_w7 9c ffffffff
R buf_r0 80 a5a50000 0
R buf_r3 8c deadbeef 0
W len_w 04 00000015
R len_r 04 00000015 0
W ctrl_go 00 00000003
R ctrl_r 00 00000001 0
W ctrl_off 00 00000000
W status_w 08 00000003
R status_r 08 00000000 0
W bad_w 10 00000001
R bad_r 0c 00000000 2
R bad_unaligned 82 00000000 2
S stream_1 1 100
S stream_4 4 100
S stream_8_bp 8 35
W buf_w2_new 88 00c0ffee
S stream_3_bp 3 60
S stream_8_full 8 100

//--- sim.f
logic/buf_pkg.sv
logic/buf_ram.sv
logic/buf_arbiter.sv
logic/lite_regs.sv
logic/dst_ctrl.sv
logic/buf_stream_top.sv
test/tb_buf_stream.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the stream buffer testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_buf_stream -f sim.f -o tb_buf_stream

./obj_dir/tb_buf_stream 2>&1 | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0

//--- test/tb_buf_stream.sv
module tb_buf_stream;

    timeunit 1ns;
    timeprecision 1ps;

    import buf_pkg::*;

    logic       clk;
    logic       rst_n;
    lite_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wready;
    resp_t      bresp;
    logic       bvalid;
    logic       bready;
    lite_addr_t araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    resp_t      rresp;
    logic       rvalid;
    logic       rready;
    logic       dst_valid;
    logic       dst_last;
    word_t      dst_data;
    logic       dst_ready;

    int errors = 0;
    int checks = 0;
    int limit = 0;        // timeout in cycles set once the cases are read
    int cycles = 0;
    int seed = 42257;

    logic [7:0]   op_q[$];
    logic [191:0] name_q[$];
    logic [31:0]  a_q[$];
    logic [31:0]  b_q[$];
    logic [31:0]  c_q[$];
    word_t        model [BUF_DEPTH];  // expected buffer contents

    buf_stream_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input logic [191:0] name, input string field,
                               input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error %0s %0s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    // bresp the register map calls for
    function automatic resp_t write_resp_for(input lite_addr_t a);
        if (a == REG_CTRL || a == REG_LEN || a == REG_STATUS) begin
            return RESP_OKAY;
        end
        if (a >= REG_BUF_BASE && a[1:0] == 2'b00) begin
            return RESP_OKAY;
        end
        return RESP_SLVERR;
    endfunction

    task automatic axi_write(input lite_addr_t a, input word_t d, output resp_t resp);
        @(negedge clk);
        awaddr  = a;
        wdata   = d;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge clk); while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input lite_addr_t a, output word_t data, output resp_t resp);
        @(negedge clk);
        araddr  = a;
        arvalid = 1'b1;
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // sample at the falling edge and judge what the last rising edge did
    task automatic collect_beats(input logic [191:0] name, input int len, input int duty);
        int    beats;
        logic  last_seen;
        logic  pv;
        logic  pl;
        logic  pr;
        word_t pd;
        beats     = 0;
        last_seen = 1'b0;
        pv        = 1'b0;
        pl        = 1'b0;
        pr        = 1'b0;
        pd        = '0;
        while (!last_seen && beats <= len) begin
            @(negedge clk);
            if (pv && pr) begin                   // beat transferred
                if (beats < len) begin
                    check_value(name, $sformatf("beat %0d data", beats), model[beats], pd);
                    check_value(name, "beat last", 32'(beats == len - 1), 32'(pl));
                end
                beats++;
                last_seen = pl;
            end else if (pv) begin                // stalled beat must hold
                check_value(name, "held valid", 32'h1, 32'(dst_valid));
                check_value(name, "held data", pd, dst_data);
                check_value(name, "held last", 32'(pl), 32'(dst_last));
            end
            pv = dst_valid;
            pl = dst_last;
            pd = dst_data;
            pr = (($unsigned($random(seed)) % 100) < duty) && !last_seen;
            dst_ready = pr;
        end
        dst_ready = 1'b0;
        check_value(name, "beat count", 32'(len), 32'(beats));
    endtask

    // host traffic competing with the stream for the ram
    task automatic host_reads(input logic [191:0] name, input int count);
        word_t rd;
        resp_t resp;
        for (int k = 0; k < count; k++) begin
            axi_read(REG_BUF_BASE + 8'(4 * k), rd, resp);
            check_value(name, "host read", model[k], rd);
            check_value(name, "host rresp", 32'(RESP_OKAY), 32'(resp));
        end
    endtask

    task automatic run_stream(input logic [191:0] name, input int len, input int duty);
        resp_t resp;
        word_t rd;
        axi_write(REG_LEN, len - 1, resp);
        axi_write(REG_CTRL, 32'h3, resp);   // enable and go
        axi_read(REG_STATUS, rd, resp);     // ready still low, so busy
        check_value(name, "status after go", 32'h1, rd);
        fork
            collect_beats(name, len, duty);
            host_reads(name, (len < 3) ? len : 3);
        join
        axi_read(REG_STATUS, rd, resp);
        check_value(name, "status after last beat", 32'h2, rd);
    endtask

    task automatic read_cases();
        int           fd;
        int           n;
        logic [7:0]   op;
        logic [191:0] name;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  c;
        logic [959:0] skip;
        fd = $fopen("test/stream_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open test/stream_cases.txt");
            return;
        end
        limit = 40;                               // reset and drain
        while ($fscanf(fd, "%s", op) == 1) begin
            a = '0;
            b = '0;
            c = '0;
            if (op == "W") begin
                n = $fscanf(fd, "%s %h %h", name, a, b);
                limit += 20;
            end else if (op == "R") begin
                n = $fscanf(fd, "%s %h %h %h", name, a, b, c);
                limit += 20;
            end else if (op == "S" && $fscanf(fd, "%s %d %d", name, a, b) == 3
                         && a >= 1 && a <= BUF_DEPTH && b >= 1 && b <= 100) begin
                // four register accesses and the host reads on top of the stream
                limit += 20 * (4 + ((a < 3) ? a : 3)) + 4 * (a + 4) * 100 / b;
            end else begin
                if (op != "#") begin
                    errors++;
                    $display("bad line in case file, starting with %0s", op);
                end
                n = $fgets(skip, fd);
                continue;
            end
            op_q.push_back(op);
            name_q.push_back(name);
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
        end
        $fclose(fd);
    endtask

    initial begin
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run went past %0d cycles without finishing", limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        resp_t       resp;
        word_t       rd;
        logic [31:0] a;
        logic [31:0] b;
        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = 4'hf;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        dst_ready = 1'b0;
        read_cases();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            a = a_q[i];
            b = b_q[i];
            if (op_q[i] == "W") begin
                axi_write(a[7:0], b, resp);
                check_value(name_q[i], "bresp", 32'(write_resp_for(a[7:0])), 32'(resp));
                if (a[7:0] >= REG_BUF_BASE && a[1:0] == 2'b00) begin
                    model[a[6:2]] = b;            // entry i at 0x80 + 4*i
                end
            end else if (op_q[i] == "R") begin
                axi_read(a[7:0], rd, resp);
                check_value(name_q[i], "rdata", b, rd);
                check_value(name_q[i], "rresp", c_q[i], 32'(resp));
            end else begin
                run_stream(name_q[i], a, b);
            end
        end
        repeat (4) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- logic/buf_stream_top.sv
module buf_stream_top (
    input  logic                clk,
    input  logic                rst_n,

    input  buf_pkg::lite_addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  buf_pkg::word_t      wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output buf_pkg::resp_t      bresp,
    output logic                bvalid,
    input  logic                bready,
    input  buf_pkg::lite_addr_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output buf_pkg::word_t      rdata,
    output buf_pkg::resp_t      rresp,
    output logic                rvalid,
    input  logic                rready,

    output logic                dst_valid,
    output logic                dst_last,
    output buf_pkg::word_t      dst_data,
    input  logic                dst_ready
);

    import buf_pkg::*;

    // host port
    logic  host_req;
    logic  host_we;
    addr_t host_addr;
    word_t host_wdata;
    logic  host_ack;
    word_t host_rdata;

    // stream port
    logic  stream_v;
    addr_t stream_a;
    word_t stream_rdata;

    // ram port
    logic  mem_en;
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;

    // control
    logic  run;
    logic  stream_go;
    addr_t last_addr;
    logic  stream_busy;
    logic  stream_done;

    lite_regs u_regs (.*);

    buf_arbiter u_arb (.*);

    buf_ram u_ram (.*);

    dst_ctrl u_dst (.*);

endmodule

//--- logic/dst_ctrl.sv
module dst_ctrl (
    input  logic           clk,
    input  logic           run,
    input  logic           stream_go,
    input  logic           dst_ready,
    input  buf_pkg::addr_t last_addr,
    input  buf_pkg::word_t stream_rdata,

    output logic           stream_v,
    output buf_pkg::addr_t stream_a,
    output logic           dst_valid,
    output logic           dst_last,
    output buf_pkg::word_t dst_data,
    output logic           stream_busy,
    output logic           stream_done
);

    import buf_pkg::*;

    logic  go_pend;        // go seen, waiting for ready
    logic  start_check;    // start qualified by ready
    logic  stream_active;  // reads in flight
    addr_t addr;           // next entry to read
    logic  at_last;

    assign at_last = (addr == last_addr);

    // go is a single pulse and may land while ready is low
    always_ff @(posedge clk) begin
        if (!run) begin
            go_pend <= 1'b0;
        end else if (stream_go) begin
            go_pend <= 1'b1;
        end else if (dst_ready) begin
            go_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!run) begin
            start_check <= 1'b0;
        end else if (dst_ready) begin
            start_check <= go_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (!run) begin
            stream_active <= 1'b0;
        end else if (dst_ready) begin
            if (start_check) begin
                stream_active <= 1'b1;
            end else if (stream_active && at_last) begin
                stream_active <= 1'b0;  // last read issued
            end
        end
    end

    // address counter from 0 up to last_addr
    always_ff @(posedge clk) begin
        if (!run) begin
            addr <= '0;
        end else if (dst_ready) begin
            if (start_check) begin
                addr <= '0;
            end else if (stream_active && !at_last) begin
                addr <= addr + 1'b1;
            end
        end
    end

    assign stream_v = stream_active & dst_ready;
    assign stream_a = addr;

    // beat flags trail the read by one ready cycle
    always_ff @(posedge clk) begin
        if (!run) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active & at_last;
        end
    end

    assign dst_data    = stream_rdata;  // held by the arbiter across stalls
    assign stream_busy = go_pend | start_check | stream_active | dst_valid;
    assign stream_done = dst_valid & dst_last & dst_ready;

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (!run)
        stream_v |-> stream_a <= last_addr
    );

endmodule

//--- logic/lite_regs.sv
module lite_regs (
    input  logic               clk,
    input  logic               rst_n,

    input  buf_pkg::lite_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  buf_pkg::word_t     wdata,
    input  logic [3:0]         wstrb,    // full-word writes only
    input  logic               wvalid,
    output logic               wready,
    output buf_pkg::resp_t     bresp,
    output logic               bvalid,
    input  logic               bready,
    input  buf_pkg::lite_addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output buf_pkg::word_t     rdata,
    output buf_pkg::resp_t     rresp,
    output logic               rvalid,
    input  logic               rready,

    output logic               host_req,
    output logic               host_we,
    output buf_pkg::addr_t     host_addr,
    output buf_pkg::word_t     host_wdata,
    input  logic               host_ack,
    input  buf_pkg::word_t     host_rdata,

    output logic               run,
    output logic               stream_go,
    output buf_pkg::addr_t     last_addr,
    input  logic               stream_busy,
    input  logic               stream_done
);

    import buf_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MEM_WAIT,
        S_WRITE_RESP,
        S_READ_RESP
    } state_t;

    state_t state;
    logic   ctrl_en;    // ctrl enable level
    logic   go_q;       // one-cycle go pulse
    addr_t  len_q;      // stream length minus one
    logic   done_q;     // sticky done
    logic   wr_accept;
    logic   rd_accept;
    logic   wr_err;
    logic   rd_err;
    word_t  rd_word;    // register read value

    // aw and w taken together and writes go before reads
    assign wr_accept = (state == S_IDLE) & awvalid & wvalid;
    assign rd_accept = (state == S_IDLE) & arvalid & ~(awvalid & wvalid);
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;
    assign bvalid    = (state == S_WRITE_RESP);
    assign rvalid    = (state == S_READ_RESP);

    assign wr_err = !in_window(awaddr)
                  && !(awaddr inside {REG_CTRL, REG_LEN, REG_STATUS});

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        if (!in_window(araddr)) begin
            case (araddr)
                REG_CTRL:   rd_word[CTRL_ENABLE_BIT] = ctrl_en;  // go reads 0
                REG_LEN:    rd_word[ADDR_W-1:0] = len_q;
                REG_STATUS: begin
                    rd_word[STATUS_BUSY_BIT] = stream_busy;
                    rd_word[STATUS_DONE_BIT] = done_q;
                end
                default:    rd_err = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            ctrl_en  <= 1'b0;
            go_q     <= 1'b0;
            len_q    <= '0;
            done_q   <= 1'b0;
            host_req <= 1'b0;
        end else begin
            go_q <= 1'b0;
            if (stream_done) begin
                done_q <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (wr_accept) begin
                        if (in_window(awaddr)) begin
                            host_req <= 1'b1;
                            state    <= S_MEM_WAIT;
                        end else begin
                            state <= S_WRITE_RESP;
                            if (awaddr == REG_CTRL) begin
                                ctrl_en <= wdata[CTRL_ENABLE_BIT];
                                go_q    <= wdata[CTRL_GO_BIT];
                                if (wdata[CTRL_GO_BIT]) begin
                                    done_q <= 1'b0;  // new stream, clear done
                                end
                            end else if (awaddr == REG_LEN) begin
                                len_q <= wdata[ADDR_W-1:0];
                            end
                        end
                    end else if (rd_accept) begin
                        if (in_window(araddr)) begin
                            host_req <= 1'b1;
                            state    <= S_MEM_WAIT;
                        end else begin
                            state <= S_READ_RESP;
                        end
                    end
                end
                S_MEM_WAIT: begin
                    if (host_ack) begin
                        host_req <= 1'b0;
                        state    <= host_we ? S_WRITE_RESP : S_READ_RESP;
                    end
                end
                S_WRITE_RESP: if (bready) state <= S_IDLE;
                S_READ_RESP:  if (rready) state <= S_IDLE;
                default:      state <= S_IDLE;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            host_we    <= 1'b1;
            host_addr  <= window_index(awaddr);
            host_wdata <= wdata;
            bresp      <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end else if (rd_accept) begin
            host_we   <= 1'b0;
            host_addr <= window_index(araddr);
            rdata     <= rd_word;  // zero on error
            rresp     <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end else if (state == S_MEM_WAIT && host_ack && !host_we) begin
            rdata <= host_rdata;
        end
    end

    assign run       = ctrl_en;
    assign stream_go = go_q;
    assign last_addr = len_q;

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

//--- logic/buf_arbiter.sv
module buf_arbiter (
    input  logic           clk,
    input  logic           rst_n,

    input  logic           stream_v,
    input  buf_pkg::addr_t stream_a,
    output buf_pkg::word_t stream_rdata,

    input  logic           host_req,
    input  logic           host_we,
    input  buf_pkg::addr_t host_addr,
    input  buf_pkg::word_t host_wdata,
    output logic           host_ack,
    output buf_pkg::word_t host_rdata,

    output logic           mem_en,
    output logic           mem_we,
    output buf_pkg::addr_t mem_addr,
    output buf_pkg::word_t mem_wdata,
    input  buf_pkg::word_t mem_rdata
);

    import buf_pkg::*;

    logic  host_grant;      // host owns the port this cycle
    logic  grant_stream_q;  // previous cycle went to the stream
    logic  grant_host_q;    // previous cycle went to the host
    word_t stream_hold;     // last word returned to the stream

    // stream always wins and the host waits for a free cycle
    // and is not regranted while its ack is out
    assign host_grant = host_req & ~stream_v & ~grant_host_q;

    assign mem_en    = stream_v | host_grant;
    assign mem_we    = host_grant & host_we;
    assign mem_addr  = stream_v ? stream_a : host_addr;
    assign mem_wdata = host_wdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_stream_q <= 1'b0;
            grant_host_q   <= 1'b0;
        end else begin
            grant_stream_q <= stream_v;
            grant_host_q   <= host_grant;
        end
    end

    // capture ram output only when it belongs to the stream
    always_ff @(posedge clk) begin
        if (grant_stream_q) begin
            stream_hold <= mem_rdata;
        end
    end

    assign stream_rdata = grant_stream_q ? mem_rdata : stream_hold;

    assign host_ack   = grant_host_q;
    assign host_rdata = grant_host_q ? mem_rdata : '0;

    // host data coming back from the ram leaves the stream word alone
    a_host_keeps_stream: assert property (
        @(posedge clk) disable iff (!rst_n)
        host_ack |-> $stable(stream_rdata)
    );

    // the slave holds its request until the ack
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        host_ack |-> host_req
    );

endmodule

//--- logic/buf_ram.sv
module buf_ram (
    input  logic           clk,
    input  logic           mem_en,
    input  logic           mem_we,
    input  buf_pkg::addr_t mem_addr,
    input  buf_pkg::word_t mem_wdata,
    output buf_pkg::word_t mem_rdata
);

    import buf_pkg::*;

    word_t mem [BUF_DEPTH];  // one word per buffer entry

    // single port with read data registered one cycle after request
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];  // holds while idle
            end
        end
    end

endmodule

//--- logic/buf_pkg.sv
package buf_pkg;

    // widths
    localparam int WORD_W      = 32;
    localparam int ADDR_W      = 5;
    localparam int LITE_ADDR_W = 8;

    typedef logic [WORD_W-1:0]      word_t;       // buffer and bus data word
    typedef logic [ADDR_W-1:0]      addr_t;       // buffer entry index
    typedef logic [LITE_ADDR_W-1:0] lite_addr_t;  // axi-lite byte address
    typedef logic [1:0]             resp_t;       // axi response code

    // buffer size
    localparam int BUF_DEPTH = 32;

    // register map in byte offsets
    localparam lite_addr_t REG_CTRL     = 8'h00;
    localparam lite_addr_t REG_LEN      = 8'h04;
    localparam lite_addr_t REG_STATUS   = 8'h08;
    localparam lite_addr_t REG_BUF_BASE = 8'h80;  // entry i at base + 4*i

    // ctrl bits
    localparam int CTRL_ENABLE_BIT = 0;  // level
    localparam int CTRL_GO_BIT     = 1;  // self-clearing pulse

    // status bits
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;  // sticky until next go

    // axi responses
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // true for a word-aligned address inside the buffer window
    function automatic logic in_window(input lite_addr_t a);
        return (a >= REG_BUF_BASE) && (a[1:0] == 2'b00);
    endfunction

    // entry index of a buffer window address
    function automatic addr_t window_index(input lite_addr_t a);
        return a[ADDR_W+1:2];
    endfunction

endpackage
